// File: compile.f
+incdir+common
common/rs_pkg.sv
hw/priority_selector.sv
rs/rs_entry.sv
rs/rs.sv
hw/issue_reg.sv
hw/rs_issue_top.sv
dv/rs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reservation-station testbench with Verilator.
# Exit status is nonzero when the build fails or the log shows a failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module rs_tb -o rs_sim \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/rs_sim > sim.log 2>&1 || { echo "Simulation exited with an error"; cat sim.log; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Result: no pass line found"; exit 1; }
echo "Result: PASS"

// File: dv/rs_vectors.txt
# dispatch rob opa_valid opa opb_valid opb dest op_type alu | cdb bus tag data
# expect rob opa opb dest alu | avail mult adder mem | stall n | idle n | reset n
avail 1 1 1
# Two values
dispatch 01 1 1111 1 2222 05 10 00
expect 01 1111 2222 05 00
dispatch 02 1 aaaa 1 5 06 10 01
expect 02 aaaa 5 06 01
# Two tags woken by cdb1 and cdb2
dispatch 03 0 0a 0 0b 07 10 02
cdb 1 0a deadbeef
cdb 2 0b cafe
idle 1
expect 03 deadbeef cafe 07 02
# Broadcast in the dispatch cycle
cdb 2 0c 12345678
dispatch 04 0 0c 1 77 08 10 00
expect 04 12345678 77 08 00
# Both buses carry the tag, cdb1 wins
dispatch 05 0 0d 1 1 09 10 00
cdb 1 0d 111
cdb 2 0d 222
idle 1
expect 05 111 1 09 00
idle 8
# Stall and fill the station
stall 30
dispatch 06 1 60 1 61 10 10 00
dispatch 07 1 70 1 71 11 10 01
dispatch 08 1 80 1 81 12 10 02
dispatch 09 1 90 1 91 13 10 00
dispatch 0a 1 a0 1 a1 14 10 01
dispatch 0b 1 b0 1 b1 15 10 02
dispatch 0c 1 c0 1 c1 16 10 00
dispatch 0d 1 d0 1 d1 17 10 01
dispatch 0e 1 e0 1 e1 18 10 02
expect 06 60 61 10 00
expect 07 70 71 11 01
expect 08 80 81 12 02
expect 09 90 91 13 00
expect 0a a0 a1 14 01
expect 0b b0 b1 15 02
expect 0c c0 c1 16 00
expect 0d d0 d1 17 01
expect 0e e0 e1 18 02
idle 30
# Multiply waits for the multiplier
avail 0 1 1
dispatch 10 1 3 1 4 1a 10 08
dispatch 11 1 5 1 6 1b 10 00
dispatch 12 1 7 1 8 1c 08 00
idle 12
avail 1 1 1
expect 10 3 4 1a 08
expect 11 5 6 1b 00
expect 12 7 8 1c 00
idle 30
# Reset drops a waiting instruction
dispatch 14 0 30 0 31 1d 10 00
reset 5
cdb 1 30 9
cdb 2 31 9
idle 10
dispatch 15 1 abc 1 def 1e 10 01
expect 15 abc def 1e 01

// File: dv/rs_tb.sv
// Self-checking testbench for rs_issue_top. Replays dv/rs_vectors.txt and
// matches every issue handshake against the expected record for its ROB index
`timescale 1ns/1ns
`include "rs_defs.svh"

module rs_tb;

	logic clock, reset;
	logic rs_load_in, rs_opa_valid, rs_opb_valid;
	rs_pkg::word_t rs_opa_in, rs_opb_in;
	rs_pkg::prf_tag_t rs_dest_in;
	rs_pkg::op_type_t rs_op_type_in;
	rs_pkg::alu_func_t rs_alu_func;
	rs_pkg::rob_idx_t rs_rob_idx_in;
	logic cdb1_valid, cdb2_valid;
	rs_pkg::prf_tag_t cdb1_tag, cdb2_tag;
	rs_pkg::word_t cdb1_data, cdb2_data;
	logic mult_available, adder_available, memory_available;
	logic rs_full, iss_ready, iss_valid;
	rs_pkg::word_t iss_opa, iss_opb;
	rs_pkg::prf_tag_t iss_dest_tag;
	rs_pkg::rob_idx_t iss_rob_idx;
	rs_pkg::op_type_t iss_op_type;
	rs_pkg::alu_func_t iss_alu_func;

	// Command table and expected issue records
	string             cmd_name [64];
	logic [63:0]       cmd_arg  [64][8];
	int                ncmd = 0;
	logic              exp_valid [`ROB_SIZE];
	rs_pkg::word_t     exp_opa   [`ROB_SIZE];
	rs_pkg::word_t     exp_opb   [`ROB_SIZE];
	rs_pkg::prf_tag_t  exp_dest  [`ROB_SIZE];
	rs_pkg::alu_func_t exp_alu   [`ROB_SIZE];
	rs_pkg::op_type_t  exp_op    [`ROB_SIZE];   // Op type as dispatched
	int                seen_cnt  [`ROB_SIZE];
	int                errors = 0;
	int                issued = 0;
	int                stall_left = 0;   // Cycles of forced iss_ready low
	logic              loaded = 1'b0;
	int                occupancy = 0;    // Occupied station slots
	rs_pkg::rob_idx_t  pass_q [$];       // Ready non-multiply work during a multiplier stall

	rs_issue_top dut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;   // 40 ns period
	end

	function automatic int arg_count(input string c);
		case (c)
			"dispatch": return 8;
			"cdb":      return 3;
			"avail":    return 3;
			"expect":   return 5;
			"stall", "idle", "reset": return 1;
			default:    return -1;
		endcase
	endfunction

	// One clock, then drive 2 ns later; one-cycle strobes drop here
	task automatic step();
		@(posedge clock);
		#2;
		rs_load_in = 1'b0;
		cdb1_valid = 1'b0;
		cdb2_valid = 1'b0;
		if (stall_left > 0)
			stall_left--;
		iss_ready = (stall_left == 0) && (($urandom % 4) != 0);   // Random backpressure
	endtask

	task automatic check_reset_state();
		if (iss_valid !== 1'b0) begin
			$display("Error: iss_valid after reset got %h expected 0", iss_valid);
			errors++;
		end
		if (rs_full !== 1'b0) begin
			$display("Error: rs_full after reset got %h expected 0", rs_full);
			errors++;
		end
	endtask

	// Work queued behind a busy multiplier must be gone once it frees up
	task automatic confirm_bypass();
		foreach (pass_q[k]) begin
			if (seen_cnt[pass_q[k]] == 0) begin
				$display("Rob index %h did not pass the multiply waiting for its unit",
					pass_q[k]);
				errors++;
			end
		end
		pass_q.delete();
	endtask

	task automatic load_vectors();
		int    fd, r, n;
		string tok, line;
		fd = $fopen("dv/rs_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file dv/rs_vectors.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				break;
			if (tok[0] == 8'h23) begin   // Comment line
				r = $fgets(line, fd);
				continue;
			end
			n = arg_count(tok);
			if (n < 0) begin
				$display("Unknown command in vector file: %s", tok);
				errors++;
				continue;
			end
			cmd_name[ncmd] = tok;
			for (int k = 0; k < n; k++)
				r = $fscanf(fd, "%h", cmd_arg[ncmd][k]);
			if (tok == "expect") begin
				exp_valid[cmd_arg[ncmd][0][4:0]] = 1'b1;
				exp_opa[cmd_arg[ncmd][0][4:0]]   = cmd_arg[ncmd][1];
				exp_opb[cmd_arg[ncmd][0][4:0]]   = cmd_arg[ncmd][2];
				exp_dest[cmd_arg[ncmd][0][4:0]]  = cmd_arg[ncmd][3][5:0];
				exp_alu[cmd_arg[ncmd][0][4:0]]   =
					rs_pkg::alu_func_t'(cmd_arg[ncmd][4][4:0]);
			end
			ncmd++;
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Issue monitor
	//////////////////////////////////////////////////

	logic              prev_valid = 1'b0, prev_ready = 1'b0, prev_reset = 1'b1;
	logic              prev_mult = 1'b1;
	rs_pkg::word_t     prev_opa, prev_opb;
	rs_pkg::prf_tag_t  prev_dest;
	rs_pkg::rob_idx_t  prev_rob;
	rs_pkg::op_type_t  prev_op;
	rs_pkg::alu_func_t prev_alu;

	always @(posedge clock) begin
		// Station occupancy from dispatches and issue register loads
		if (reset) begin
			occupancy = 0;
		end else begin
			if ((!prev_valid || prev_ready) && iss_valid)
				occupancy--;   // Slot handed over on the last edge
			if (rs_full !== (occupancy == `RS_SIZE)) begin
				$display("Error: rs_full got %h expected %h", rs_full,
					occupancy == `RS_SIZE);
				errors++;
			end
			if (rs_load_in && !rs_full)
				occupancy++;
		end
		if (!reset && !prev_reset) begin
			// Stalled output must not move
			if (prev_valid && !prev_ready && (iss_opa !== prev_opa || iss_opb !== prev_opb ||
				iss_dest_tag !== prev_dest || iss_rob_idx !== prev_rob ||
				iss_op_type !== prev_op || iss_alu_func !== prev_alu)) begin
				$display("Error: iss fields changed while stalled, rob %h was %h",
					iss_rob_idx, prev_rob);
				errors++;
			end
			// Newly loaded multiply must have seen the multiplier available
			if ((!prev_valid || prev_ready) && iss_valid &&
				iss_alu_func == rs_pkg::alu_mulq && iss_op_type[5:3] == 3'd2 &&
				!prev_mult) begin
				$display("Multiply rob %h was selected while the multiplier was busy",
					iss_rob_idx);
				errors++;
			end
			if (iss_valid && iss_ready) begin
				issued++;
				if (!exp_valid[iss_rob_idx]) begin
					$display("Unexpected issue of rob index %h", iss_rob_idx);
					errors++;
				end else begin
					seen_cnt[iss_rob_idx]++;
					if (iss_opa !== exp_opa[iss_rob_idx]) begin
						$display("Error: iss_opa rob %h got %h expected %h",
							iss_rob_idx, iss_opa, exp_opa[iss_rob_idx]);
						errors++;
					end
					if (iss_opb !== exp_opb[iss_rob_idx]) begin
						$display("Error: iss_opb rob %h got %h expected %h",
							iss_rob_idx, iss_opb, exp_opb[iss_rob_idx]);
						errors++;
					end
					if (iss_dest_tag !== exp_dest[iss_rob_idx]) begin
						$display("Error: iss_dest_tag rob %h got %h expected %h",
							iss_rob_idx, iss_dest_tag, exp_dest[iss_rob_idx]);
						errors++;
					end
					if (iss_op_type !== exp_op[iss_rob_idx]) begin
						$display("Error: iss_op_type rob %h got %h expected %h",
							iss_rob_idx, iss_op_type, exp_op[iss_rob_idx]);
						errors++;
					end
					if (iss_alu_func !== exp_alu[iss_rob_idx]) begin
						$display("Error: iss_alu_func rob %h got %h expected %h",
							iss_rob_idx, iss_alu_func, exp_alu[iss_rob_idx]);
						errors++;
					end
				end
			end
		end
		prev_reset = reset;
		prev_valid = iss_valid;
		prev_ready = iss_ready;
		prev_mult  = mult_available;
		prev_opa   = iss_opa;
		prev_opb   = iss_opb;
		prev_dest  = iss_dest_tag;
		prev_rob   = iss_rob_idx;
		prev_op    = iss_op_type;
		prev_alu   = iss_alu_func;
	end

	// Watchdog budget scales with the command count
	initial begin
		int limit;
		wait (loaded);
		limit = ncmd * 20 + 200;
		repeat (limit) @(posedge clock);
		$display("Timeout after %0d cycles, not every instruction issued", limit);
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Command replay
	//////////////////////////////////////////////////

	initial begin
		int pending;
		void'($urandom(61));
		reset = 1'b1;
		rs_load_in = 1'b0;
		rs_opa_valid = 1'b0;
		rs_opb_valid = 1'b0;
		rs_opa_in = '0;
		rs_opb_in = '0;
		rs_dest_in = '0;
		rs_op_type_in = '0;
		rs_alu_func = rs_pkg::alu_default;
		rs_rob_idx_in = '0;
		cdb1_valid = 1'b0;
		cdb1_tag = '0;
		cdb1_data = '0;
		cdb2_valid = 1'b0;
		cdb2_tag = '0;
		cdb2_data = '0;
		mult_available = 1'b1;
		adder_available = 1'b1;
		memory_available = 1'b1;
		iss_ready = 1'b0;
		for (int i = 0; i < `ROB_SIZE; i++) begin
			exp_valid[i] = 1'b0;
			exp_op[i]    = '0;
			seen_cnt[i]  = 0;
		end
		load_vectors();
		loaded = 1'b1;
		repeat (5) @(posedge clock);
		#2 reset = 1'b0;
		check_reset_state();
		for (int c = 0; c < ncmd; c++) begin
			case (cmd_name[c])
				"dispatch": begin
					while (rs_full)
						step();
					rs_load_in    = 1'b1;
					rs_rob_idx_in = cmd_arg[c][0][4:0];
					rs_opa_valid  = cmd_arg[c][1][0];
					rs_opa_in     = cmd_arg[c][2];
					rs_opb_valid  = cmd_arg[c][3][0];
					rs_opb_in     = cmd_arg[c][4];
					rs_dest_in    = cmd_arg[c][5][5:0];
					rs_op_type_in = cmd_arg[c][6][5:0];
					rs_alu_func   = rs_pkg::alu_func_t'(cmd_arg[c][7][4:0]);
					exp_op[rs_rob_idx_in] = rs_op_type_in;
					// Ready work that must not wait for the multiplier
					if (!mult_available && adder_available && memory_available &&
						rs_opa_valid && rs_opb_valid &&
						!(rs_op_type_in[5:3] == 3'd2 && rs_alu_func == rs_pkg::alu_mulq))
						pass_q.push_back(rs_rob_idx_in);
					step();
				end
				"cdb": begin   // Held until the next clock step
					if (cmd_arg[c][0] == 64'd1) begin
						cdb1_valid = 1'b1;
						cdb1_tag   = cmd_arg[c][1][5:0];
						cdb1_data  = cmd_arg[c][2];
					end else begin
						cdb2_valid = 1'b1;
						cdb2_tag   = cmd_arg[c][1][5:0];
						cdb2_data  = cmd_arg[c][2];
					end
				end
				"avail": begin
					if (!mult_available && cmd_arg[c][0][0])
						confirm_bypass();
					mult_available   = cmd_arg[c][0][0];
					adder_available  = cmd_arg[c][1][0];
					memory_available = cmd_arg[c][2][0];
				end
				"stall": begin
					stall_left = int'(cmd_arg[c][0][15:0]);
					iss_ready  = 1'b0;
				end
				"idle": repeat (int'(cmd_arg[c][0][15:0])) step();
				"reset": begin
					reset = 1'b1;
					pass_q.delete();
					repeat (int'(cmd_arg[c][0][15:0])) step();
					reset = 1'b0;
					check_reset_state();
				end
				default: ;   // Expect lines were taken at load time
			endcase
		end
		// Drain until every expected index has issued
		do begin
			pending = 0;
			for (int i = 0; i < `ROB_SIZE; i++)
				if (exp_valid[i] && seen_cnt[i] == 0)
					pending++;
			if (pending > 0)
				step();
		end while (pending > 0);
		repeat (20) step();   // Room for duplicates to show
		for (int i = 0; i < `ROB_SIZE; i++) begin
			if (exp_valid[i] && seen_cnt[i] != 1) begin
				$display("Rob index %h issued %0d times instead of once", i[4:0],
					seen_cnt[i]);
				errors++;
			end
		end
		$display("Commands %0d, issued %0d, errors %0d", ncmd, issued, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: hw/rs_issue_top.sv
// Top level of the issue stage. The reservation station feeds the issue
// register, which presents one instruction at a time to the execution units
`timescale 1ns/1ns

module rs_issue_top (
	input                          clock,
	input                          reset,
	input                          rs_load_in,
	input  rs_pkg::word_t          rs_opa_in,
	input  rs_pkg::word_t          rs_opb_in,
	input                          rs_opa_valid,
	input                          rs_opb_valid,
	input  rs_pkg::prf_tag_t       rs_dest_in,
	input  rs_pkg::op_type_t       rs_op_type_in,
	input  rs_pkg::alu_func_t      rs_alu_func,
	input  rs_pkg::rob_idx_t       rs_rob_idx_in,
	input                          cdb1_valid,
	input  rs_pkg::prf_tag_t       cdb1_tag,
	input  rs_pkg::word_t          cdb1_data,
	input                          cdb2_valid,
	input  rs_pkg::prf_tag_t       cdb2_tag,
	input  rs_pkg::word_t          cdb2_data,
	input                          mult_available,
	input                          adder_available,
	input                          memory_available,
	output logic                   rs_full,
	input                          iss_ready,
	output logic                   iss_valid,
	output rs_pkg::word_t          iss_opa,
	output rs_pkg::word_t          iss_opb,
	output rs_pkg::prf_tag_t       iss_dest_tag,
	output rs_pkg::rob_idx_t       iss_rob_idx,
	output rs_pkg::op_type_t       iss_op_type,
	output rs_pkg::alu_func_t      iss_alu_func
);

	// Station to issue register
	logic                rs_out_valid;
	logic                issue_accept;
	rs_pkg::word_t       rs_opa_out;
	rs_pkg::word_t       rs_opb_out;
	rs_pkg::prf_tag_t    rs_dest_tag_out;
	rs_pkg::rob_idx_t    rs_rob_idx_out;
	rs_pkg::op_type_t    rs_op_type_out;
	rs_pkg::alu_func_t   rs_alu_func_out;

	rs u_rs (.*);   // All port names match

	issue_reg u_issue_reg (
		.clock        (clock),
		.reset        (reset),
		.in_valid     (rs_out_valid),
		.in_opa       (rs_opa_out),
		.in_opb       (rs_opb_out),
		.in_dest_tag  (rs_dest_tag_out),
		.in_rob_idx   (rs_rob_idx_out),
		.in_op_type   (rs_op_type_out),
		.in_alu_func  (rs_alu_func_out),
		.issue_accept (issue_accept),
		.iss_valid    (iss_valid),
		.iss_ready    (iss_ready),
		.iss_opa      (iss_opa),
		.iss_opb      (iss_opb),
		.iss_dest_tag (iss_dest_tag),
		.iss_rob_idx  (iss_rob_idx),
		.iss_op_type  (iss_op_type),
		.iss_alu_func (iss_alu_func)
	);

endmodule

// File: hw/issue_reg.sv
// One-deep pipeline register between the station and the execution units.
// Loads when empty or when downstream drains it, valid/ready toward the units
`timescale 1ns/1ns

module issue_reg (
	input                          clock,
	input                          reset,
	input                          in_valid,       // Station offers an instruction
	input  rs_pkg::word_t          in_opa,
	input  rs_pkg::word_t          in_opb,
	input  rs_pkg::prf_tag_t       in_dest_tag,
	input  rs_pkg::rob_idx_t       in_rob_idx,
	input  rs_pkg::op_type_t       in_op_type,
	input  rs_pkg::alu_func_t      in_alu_func,
	output logic                   issue_accept,   // Register can take new data
	output logic                   iss_valid,
	input                          iss_ready,
	output rs_pkg::word_t          iss_opa,
	output rs_pkg::word_t          iss_opb,
	output rs_pkg::prf_tag_t       iss_dest_tag,
	output rs_pkg::rob_idx_t       iss_rob_idx,
	output rs_pkg::op_type_t       iss_op_type,
	output rs_pkg::alu_func_t      iss_alu_func
);

	assign issue_accept = !iss_valid || iss_ready;   // Empty or draining

	always_ff @(posedge clock) begin
		if (reset)
			iss_valid <= 1'b0;
		else if (issue_accept)
			iss_valid <= in_valid;
	end

	always_ff @(posedge clock) begin
		if (issue_accept && in_valid) begin
			iss_opa      <= in_opa;
			iss_opb      <= in_opb;
			iss_dest_tag <= in_dest_tag;
			iss_rob_idx  <= in_rob_idx;
			iss_op_type  <= in_op_type;
			iss_alu_func <= in_alu_func;
		end
	end

	// Stalled output keeps its instruction intact
	a_hold: assert property (@(posedge clock) disable iff (reset)
		iss_valid && !iss_ready |=> iss_valid && $stable(iss_opa) && $stable(iss_opb) &&
			$stable(iss_dest_tag) && $stable(iss_rob_idx) && $stable(iss_op_type) &&
			$stable(iss_alu_func));

endmodule

// File: rs/rs.sv
// Eight-slot reservation station. Dispatch lands in the lowest free slot,
// the lowest ready slot is offered to the issue register each cycle and is
// freed when issue_accept takes it
`timescale 1ns/1ns
`include "rs_defs.svh"

module rs (
	input                          clock,
	input                          reset,
	input                          rs_load_in,        // Dispatch strobe
	input  rs_pkg::word_t          rs_opa_in,
	input  rs_pkg::word_t          rs_opb_in,
	input                          rs_opa_valid,      // 0 means tag in low bits
	input                          rs_opb_valid,
	input  rs_pkg::prf_tag_t       rs_dest_in,
	input  rs_pkg::op_type_t       rs_op_type_in,
	input  rs_pkg::alu_func_t      rs_alu_func,
	input  rs_pkg::rob_idx_t       rs_rob_idx_in,
	input                          cdb1_valid,
	input  rs_pkg::prf_tag_t       cdb1_tag,
	input  rs_pkg::word_t          cdb1_data,
	input                          cdb2_valid,
	input  rs_pkg::prf_tag_t       cdb2_tag,
	input  rs_pkg::word_t          cdb2_data,
	input                          mult_available,
	input                          adder_available,
	input                          memory_available,
	input                          issue_accept,      // Issue register takes output
	output logic                   rs_full,           // No free slot
	output logic                   rs_out_valid,
	output rs_pkg::word_t          rs_opa_out,
	output rs_pkg::word_t          rs_opb_out,
	output rs_pkg::prf_tag_t       rs_dest_tag_out,
	output rs_pkg::rob_idx_t       rs_rob_idx_out,
	output rs_pkg::op_type_t       rs_op_type_out,
	output rs_pkg::alu_func_t      rs_alu_func_out
);

	logic [`RS_SIZE-1:0] free_vec;     // Slot free flags
	logic [`RS_SIZE-1:0] ready_vec;    // Slot ready flags
	logic [`RS_SIZE-1:0] load_gnt;     // One-hot dispatch target
	logic [`RS_SIZE-1:0] use_gnt;      // One-hot issue pick
	rs_pkg::fu_select_t  fu_class;     // Class of incoming instruction

	rs_pkg::word_t       opa_vec      [`RS_SIZE];
	rs_pkg::word_t       opb_vec      [`RS_SIZE];
	rs_pkg::prf_tag_t    dest_vec     [`RS_SIZE];
	rs_pkg::op_type_t    op_type_vec  [`RS_SIZE];
	rs_pkg::alu_func_t   alu_func_vec [`RS_SIZE];
	rs_pkg::rob_idx_t    rob_idx_vec  [`RS_SIZE];

	//////////////////////////////////////////////////
	// Unit classification
	//////////////////////////////////////////////////

	always_comb begin
		if (rs_op_type_in[5:3] == 3'd2 && rs_alu_func == rs_pkg::alu_mulq)
			fu_class = rs_pkg::use_multiplier;   // Integer multiply
		else if (rs_op_type_in[5:3] == 3'd1 || rs_op_type_in[5:3] == 3'd4 ||
			rs_op_type_in[5:3] == 3'd5)
			fu_class = rs_pkg::use_memory;       // Loads and stores
		else
			fu_class = rs_pkg::use_adder;
	end

	//////////////////////////////////////////////////
	// Slots and selectors
	//////////////////////////////////////////////////

	for (genvar i = 0; i < `RS_SIZE; i++) begin : g_slot
		rs_entry u_entry (
			.clock            (clock),
			.reset            (reset),
			.load             (load_gnt[i]),
			.use_enable       (use_gnt[i]),
			.opa_in           (rs_opa_in),
			.opb_in           (rs_opb_in),
			.opa_valid        (rs_opa_valid),
			.opb_valid        (rs_opb_valid),
			.dest_in          (rs_dest_in),
			.op_type_in       (rs_op_type_in),
			.alu_func_in      (rs_alu_func),
			.rob_idx_in       (rs_rob_idx_in),
			.fu_in            (fu_class),
			.cdb1_valid       (cdb1_valid),
			.cdb1_tag         (cdb1_tag),
			.cdb1_data        (cdb1_data),
			.cdb2_valid       (cdb2_valid),
			.cdb2_tag         (cdb2_tag),
			.cdb2_data        (cdb2_data),
			.mult_available   (mult_available),
			.adder_available  (adder_available),
			.memory_available (memory_available),
			.free_out         (free_vec[i]),
			.ready_out        (ready_vec[i]),
			.opa_out          (opa_vec[i]),
			.opb_out          (opb_vec[i]),
			.dest_out         (dest_vec[i]),
			.op_type_out      (op_type_vec[i]),
			.alu_func_out     (alu_func_vec[i]),
			.rob_idx_out      (rob_idx_vec[i])
		);
	end

	priority_selector #(.SIZE(`RS_SIZE)) u_load_sel (   // Lowest free slot
		.req (free_vec),
		.en  (rs_load_in),
		.gnt (load_gnt)
	);

	priority_selector #(.SIZE(`RS_SIZE)) u_use_sel (    // Lowest ready slot
		.req (ready_vec),
		.en  (issue_accept),   // Hold slots while issue is stalled
		.gnt (use_gnt)
	);

	assign rs_full = (free_vec == '0);

	// Output mux, grant is one-hot
	always_comb begin
		rs_out_valid    = |use_gnt;
		rs_opa_out      = '0;
		rs_opb_out      = '0;
		rs_dest_tag_out = '0;
		rs_rob_idx_out  = '0;
		rs_op_type_out  = '0;
		rs_alu_func_out = rs_pkg::alu_default;
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (use_gnt[i]) begin
				rs_opa_out      = opa_vec[i];
				rs_opb_out      = opb_vec[i];
				rs_dest_tag_out = dest_vec[i];
				rs_rob_idx_out  = rob_idx_vec[i];
				rs_op_type_out  = op_type_vec[i];
				rs_alu_func_out = alu_func_vec[i];
			end
		end
	end

	// Dispatch source honours the full flag
	a_no_load_full: assert property (@(posedge clock) disable iff (reset)
		rs_load_in |-> !rs_full);

endmodule

// File: rs/rs_entry.sv
// One reservation-station slot. Holds a dispatched instruction, snoops both
// CDBs for missing operands and reports whether it is free or ready to issue
`timescale 1ns/1ns

module rs_entry (
	input                          clock,
	input                          reset,
	input                          load,              // Dispatch into this slot
	input                          use_enable,        // Slot taken by issue
	input  rs_pkg::word_t          opa_in,            // Value or tag
	input  rs_pkg::word_t          opb_in,            // Value or tag
	input                          opa_valid,         // 1 means opa_in is a value
	input                          opb_valid,         // 1 means opb_in is a value
	input  rs_pkg::prf_tag_t       dest_in,
	input  rs_pkg::op_type_t       op_type_in,
	input  rs_pkg::alu_func_t      alu_func_in,
	input  rs_pkg::rob_idx_t       rob_idx_in,
	input  rs_pkg::fu_select_t     fu_in,             // Unit class from rs
	input                          cdb1_valid,
	input  rs_pkg::prf_tag_t       cdb1_tag,
	input  rs_pkg::word_t          cdb1_data,
	input                          cdb2_valid,
	input  rs_pkg::prf_tag_t       cdb2_tag,
	input  rs_pkg::word_t          cdb2_data,
	input                          mult_available,
	input                          adder_available,
	input                          memory_available,
	output logic                   free_out,          // Slot can take a dispatch
	output logic                   ready_out,         // Operands complete, unit free
	output rs_pkg::word_t          opa_out,
	output rs_pkg::word_t          opb_out,
	output rs_pkg::prf_tag_t       dest_out,
	output rs_pkg::op_type_t       op_type_out,
	output rs_pkg::alu_func_t      alu_func_out,
	output rs_pkg::rob_idx_t       rob_idx_out
);

	rs_pkg::entry_state_t state;
	rs_pkg::fu_select_t   fu_r;                       // Stored unit class
	logic                 opa_vld_r, opb_vld_r;       // Stored value flags
	rs_pkg::word_t        src_a, src_b;               // Operand before snoop
	logic                 src_a_vld, src_b_vld;
	rs_pkg::word_t        opa_nxt, opb_nxt;           // Operand after snoop
	logic                 opa_vld_nxt, opb_vld_nxt;
	logic                 unit_ok;

	//////////////////////////////////////////////////
	// CDB snoop, on stored or incoming operands
	//////////////////////////////////////////////////

	always_comb begin
		src_a       = load ? opa_in : opa_out;
		src_b       = load ? opb_in : opb_out;
		src_a_vld   = load ? opa_valid : opa_vld_r;
		src_b_vld   = load ? opb_valid : opb_vld_r;
		opa_nxt     = src_a;
		opb_nxt     = src_b;
		opa_vld_nxt = src_a_vld;
		opb_vld_nxt = src_b_vld;
		if (!src_a_vld && cdb1_valid && cdb1_tag == rs_pkg::prf_tag_t'(src_a)) begin
			opa_nxt     = cdb1_data;   // cdb1 has priority
			opa_vld_nxt = 1'b1;
		end else if (!src_a_vld && cdb2_valid && cdb2_tag == rs_pkg::prf_tag_t'(src_a)) begin
			opa_nxt     = cdb2_data;
			opa_vld_nxt = 1'b1;
		end
		if (!src_b_vld && cdb1_valid && cdb1_tag == rs_pkg::prf_tag_t'(src_b)) begin
			opb_nxt     = cdb1_data;
			opb_vld_nxt = 1'b1;
		end else if (!src_b_vld && cdb2_valid && cdb2_tag == rs_pkg::prf_tag_t'(src_b)) begin
			opb_nxt     = cdb2_data;
			opb_vld_nxt = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Slot FSM and storage
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rs_pkg::st_free;
		end else begin
			case (state)
				rs_pkg::st_free: if (load) state <= rs_pkg::st_wait;
				rs_pkg::st_wait: if (use_enable) state <= rs_pkg::st_free;
				default:         state <= rs_pkg::st_free;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (load || state == rs_pkg::st_wait) begin   // Keep snooping while waiting
			opa_out   <= opa_nxt;
			opb_out   <= opb_nxt;
			opa_vld_r <= opa_vld_nxt;
			opb_vld_r <= opb_vld_nxt;
		end
		if (load) begin
			dest_out     <= dest_in;
			op_type_out  <= op_type_in;
			alu_func_out <= alu_func_in;
			rob_idx_out  <= rob_idx_in;
			fu_r         <= fu_in;
		end
	end

	always_comb begin
		case (fu_r)
			rs_pkg::use_multiplier: unit_ok = mult_available;
			rs_pkg::use_memory:     unit_ok = memory_available;
			default:                unit_ok = adder_available;
		endcase
	end

	assign free_out  = (state == rs_pkg::st_free);
	assign ready_out = (state == rs_pkg::st_wait) && opa_vld_r && opb_vld_r && unit_ok;

	// Free-slot selector never targets an occupied slot
	a_load_free: assert property (@(posedge clock) disable iff (reset)
		load |-> state == rs_pkg::st_free);
	// Issue grant only on a ready slot
	a_use_ready: assert property (@(posedge clock) disable iff (reset)
		use_enable |-> ready_out);

endmodule

// File: hw/priority_selector.sv
// Fixed-priority arbiter. Grants the lowest set request bit as a
// one-hot vector while en is high, zero otherwise
`timescale 1ns/1ns

module priority_selector #(
	parameter int SIZE = 8   // Request vector width
) (
	input        [SIZE-1:0] req,   // Request per slot
	input                   en,    // Grant enable
	output logic [SIZE-1:0] gnt    // One-hot grant
);

	logic found;   // Lower bit already granted

	always_comb begin
		gnt   = '0;
		found = 1'b0;
		for (int i = 0; i < SIZE; i++) begin
			if (en && req[i] && !found) begin
				gnt[i] = 1'b1;   // Lowest index wins
				found  = 1'b1;
			end
		end
		// Never more than one grant, never a grant without a request
		assert ($onehot0(gnt) && ((gnt & ~req) == '0))
			else $error("priority_selector: bad grant %h for req %h", gnt, req);
	end

endmodule

// File: common/rs_pkg.sv
// Shared types for the reservation station and issue register.
// RTL files refer to these by scoped name, rs_pkg::name
`include "rs_defs.svh"

package rs_pkg;

	typedef logic [$clog2(`PRF_SIZE)-1:0] prf_tag_t;   // Physical register tag
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;   // Reorder-buffer index
	typedef logic [`DATA_W-1:0]           word_t;      // Operand value
	typedef logic [5:0]                   op_type_t;   // Decoder type, [5:3] is class

	// ALU function codes from the decoder
	typedef enum logic [4:0] {
		alu_addq    = 5'h00,
		alu_subq    = 5'h01,
		alu_and     = 5'h02,
		alu_bic     = 5'h03,
		alu_bis     = 5'h04,
		alu_xor     = 5'h05,
		alu_srl     = 5'h06,
		alu_sll     = 5'h07,
		alu_mulq    = 5'h08,
		alu_cmpeq   = 5'h09,
		alu_cmplt   = 5'h0a,
		alu_default = 5'h1f   // Idle output
	} alu_func_t;

	typedef enum logic [1:0] {
		use_adder, use_multiplier, use_memory
	} fu_select_t;

	typedef enum logic {st_free, st_wait} entry_state_t;   // Slot FSM

endpackage

// File: common/rs_defs.svh
// Size and width constants for the reservation station and issue stage.
// Include wherever a slot count or a data width is needed
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

//////////////////////////////////////////////////
// Structure sizes
//////////////////////////////////////////////////

`define RS_SIZE   8    // Station slots
`define PRF_SIZE  64   // Physical registers, 6-bit tags
`define ROB_SIZE  32   // Reorder-buffer entries, 5-bit index

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

`define DATA_W    64   // Operand and CDB data width

`endif
